/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_i3c_ctrl
FILELIST  := list.f
OBJDIR    := obj_dir
SIM_BIN   := $(OBJDIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/addr_receiver.sv */
//////////////////////////////////////////////////
// Collects the first byte after START or repeated
// START, reports it with RnW and flags a match
// against the static, dynamic or broadcast address.
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i3c_consts.svh"

module addr_receiver (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  i3c_bus_pkg::bus_state_t  bus_i,
  input  i3c_cfg_pkg::cfg_t        cfg_i,
  output logic [`I3C_BYTE_W-1:0]   bus_addr_o,
  output logic                     bus_addr_valid_o,
  output logic                     addr_match_o,
  output logic                     xfer_in_progress_o
);

  import i3c_bus_pkg::*;

  localparam int CntW = $clog2(`I3C_BYTE_W);

  rx_state_e              state_q;
  logic [CntW-1:0]        bit_cnt_q;
  logic [`I3C_BYTE_W-2:0] shift_q;
  logic [`I3C_BYTE_W-1:0] byte_c;
  logic [`I3C_ADDR_W-1:0] addr_c;
  logic                   bit_take;
  logic                   byte_done;
  logic                   hit;

  // Byte as it stands with the current SDA bit appended
  assign byte_c   = {shift_q, bus_i.sda};
  assign addr_c   = byte_c[`I3C_BYTE_W-1:1];
  assign bit_take = (state_q == RX_ADDR) && bus_i.scl_rise;
  assign byte_done = bit_take && cfg_i.enable &&
                     (bit_cnt_q == CntW'(`I3C_BYTE_W - 1));

  assign hit = (cfg_i.sta_valid && addr_c == cfg_i.sta_addr) ||
               (cfg_i.dyn_valid && addr_c == cfg_i.dyn_addr) ||
               (addr_c == `I3C_BROADCAST_ADDR);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q          <= RX_IDLE;
      bit_cnt_q        <= '0;
      bus_addr_valid_o <= 1'b0;
      addr_match_o     <= 1'b0;
    end else begin
      bus_addr_valid_o <= byte_done;
      addr_match_o     <= byte_done & hit;
      if (!cfg_i.enable || bus_i.stop) begin
        // Partial byte is dropped
        state_q <= RX_IDLE;
      end else if (bus_i.start || bus_i.rstart) begin
        state_q   <= RX_ADDR;
        bit_cnt_q <= '0;
      end else if (byte_done) begin
        state_q <= RX_BUSY;
      end else if (bit_take) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (bit_take) begin
      shift_q <= byte_c[`I3C_BYTE_W-2:0];
    end
    if (byte_done) begin
      bus_addr_o <= byte_c;
    end
  end

  assign xfer_in_progress_o = (state_q != RX_IDLE);

  a_match_with_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    addr_match_o |-> bus_addr_valid_o
  );

  a_valid_leaves_addr: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(bus_addr_valid_o) |-> ($past(state_q) == RX_ADDR) && (state_q == RX_BUSY)
  );

endmodule

/* hw/bus_monitor.sv */
//////////////////////////////////////////////////
// Synchronizes and deglitches SCL/SDA, then
// decodes START, repeated START, STOP and SCL
// rising edges as one-cycle strobes.
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i3c_consts.svh"

module bus_monitor (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  input  logic [`I3C_FILT_W-1:0]     filt_cycles_i,
  input  logic                       enable_i,
  output i3c_bus_pkg::bus_state_t    state_o
);

  // Line 0 is SCL, line 1 is SDA
  logic [1:0] raw;
  logic [1:0] filt;

  logic scl_prev_q;
  logic sda_prev_q;
  logic open_q;
  logic scl_rise_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;

  logic scl_high;
  logic sda_fall;
  logic sda_rise;

  assign raw = {sda_i, scl_i};

  for (genvar i = 0; i < 2; i++) begin : g_line
    logic [`I3C_SYNC_STAGES-1:0] sync_q;
    logic [`I3C_FILT_W-1:0]      cnt_q;
    logic [`I3C_FILT_W:0]        cnt_inc;
    logic                        level_q;

    assign cnt_inc = {1'b0, cnt_q} + 1'b1;
    assign filt[i] = level_q;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        sync_q  <= '1;
        cnt_q   <= '0;
        level_q <= 1'b1;
      end else begin
        sync_q <= {sync_q[`I3C_SYNC_STAGES-2:0], raw[i]};
        if (sync_q[`I3C_SYNC_STAGES-1] == level_q) begin
          cnt_q <= '0;
        end else if (cnt_inc >= {1'b0, filt_cycles_i}) begin
          // Held long enough, accept the new level
          level_q <= sync_q[`I3C_SYNC_STAGES-1];
          cnt_q   <= '0;
        end else begin
          cnt_q <= cnt_inc[`I3C_FILT_W-1:0];
        end
      end
    end
  end

  // Conditions on the filtered levels
  assign scl_high = filt[0] & scl_prev_q;
  assign sda_fall = sda_prev_q & ~filt[1] & scl_high;
  assign sda_rise = ~sda_prev_q & filt[1] & scl_high;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
      open_q     <= 1'b0;
      scl_rise_q <= 1'b0;
      start_q    <= 1'b0;
      rstart_q   <= 1'b0;
      stop_q     <= 1'b0;
    end else begin
      scl_prev_q <= filt[0];
      sda_prev_q <= filt[1];
      scl_rise_q <= enable_i & ~scl_prev_q & filt[0];
      start_q    <= enable_i & sda_fall & ~open_q;
      rstart_q   <= enable_i & sda_fall & open_q;
      stop_q     <= enable_i & sda_rise;
      if (!enable_i || sda_rise) begin
        open_q <= 1'b0;
      end else if (sda_fall) begin
        open_q <= 1'b1;
      end
    end
  end

  // Levels are delayed to line up with the strobes
  assign state_o = '{
    scl:      scl_prev_q,
    sda:      sda_prev_q,
    scl_rise: scl_rise_q,
    start:    start_q,
    rstart:   rstart_q,
    stop:     stop_q
  };

  a_cond_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $onehot0({start_q, rstart_q, stop_q})
  );

endmodule

/* hw/ctrl_config.sv */
//////////////////////////////////////////////////
// Target configuration registers. A write strobe
// updates one register; all are presented as a
// single packed struct one cycle later.
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i3c_consts.svh"

module ctrl_config (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        cfg_wr_i,
  input  i3c_cfg_pkg::cfg_reg_e       cfg_sel_i,
  input  logic [`I3C_CFG_DATA_W-1:0]  cfg_wdata_i,
  output i3c_cfg_pkg::cfg_t           cfg_o
);

  import i3c_cfg_pkg::*;

  logic [`I3C_ADDR_W-1:0] sta_addr_q;
  logic [`I3C_ADDR_W-1:0] dyn_addr_q;
  logic                   sta_valid_q;
  logic                   dyn_valid_q;
  logic [`I3C_FILT_W-1:0] filt_q;
  logic                   enable_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sta_valid_q <= 1'b0;
      dyn_valid_q <= 1'b0;
      filt_q      <= `I3C_FILT_W'(`I3C_FILT_RESET);
      enable_q    <= 1'b0;
    end else if (cfg_wr_i) begin
      case (cfg_sel_i)
        REG_STA_ADDR: sta_valid_q <= cfg_wdata_i[`I3C_ADDR_W];
        REG_DYN_ADDR: dyn_valid_q <= cfg_wdata_i[`I3C_ADDR_W];
        REG_FILT:     filt_q      <= cfg_wdata_i[`I3C_FILT_W-1:0];
        REG_ENABLE:   enable_q    <= cfg_wdata_i[0];
        default:      ;
      endcase
    end
  end

  // Address values, only meaningful with their valid flags
  always_ff @(posedge clk_i) begin
    if (cfg_wr_i && cfg_sel_i == REG_STA_ADDR) begin
      sta_addr_q <= cfg_wdata_i[`I3C_ADDR_W-1:0];
    end
    if (cfg_wr_i && cfg_sel_i == REG_DYN_ADDR) begin
      dyn_addr_q <= cfg_wdata_i[`I3C_ADDR_W-1:0];
    end
  end

  assign cfg_o = '{
    sta_addr:    sta_addr_q,
    sta_valid:   sta_valid_q,
    dyn_addr:    dyn_addr_q,
    dyn_valid:   dyn_valid_q,
    filt_cycles: filt_q,
    enable:      enable_q
  };

  a_sel_known: assert property (
    @(posedge clk_i) disable iff (rst_i)
    cfg_wr_i |-> !$isunknown(cfg_sel_i)
  );

endmodule

/* hw/i3c_bus_pkg.sv */
//////////////////////////////////////////////////
// Types describing the observed bus state and
// the address receiver FSM.
//////////////////////////////////////////////////

package i3c_bus_pkg;

  // Filtered levels plus one-cycle condition strobes
  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic start;
    logic rstart;
    logic stop;
  } bus_state_t;

  // Address receiver states
  typedef enum logic [1:0] {
    RX_IDLE = 2'd0,
    RX_ADDR = 2'd1,
    RX_BUSY = 2'd2
  } rx_state_e;

endpackage

/* hw/i3c_cfg_pkg.sv */
//////////////////////////////////////////////////
// Types for the configuration register block:
// write select and the packed configuration.
//////////////////////////////////////////////////

`include "i3c_consts.svh"

package i3c_cfg_pkg;

  // Register select on the write port
  typedef enum logic [1:0] {
    REG_STA_ADDR = 2'd0,
    REG_DYN_ADDR = 2'd1,
    REG_FILT     = 2'd2,
    REG_ENABLE   = 2'd3
  } cfg_reg_e;

  typedef struct packed {
    logic [`I3C_ADDR_W-1:0] sta_addr;
    logic                   sta_valid;
    logic [`I3C_ADDR_W-1:0] dyn_addr;
    logic                   dyn_valid;
    logic [`I3C_FILT_W-1:0] filt_cycles;
    logic                   enable;
  } cfg_t;

endpackage

/* hw/i3c_consts.svh */
//////////////////////////////////////////////////
// Shared constants for the I3C target front end.
// Include wherever a width or reset value is needed.
//////////////////////////////////////////////////

`ifndef I3C_CONSTS_SVH
`define I3C_CONSTS_SVH

// Flip-flop stages on SDA and SCL
`define I3C_SYNC_STAGES 2

// Deglitch counter width and its value after reset
`define I3C_FILT_W 8
`define I3C_FILT_RESET 4

// Address and address byte widths
`define I3C_ADDR_W 7
`define I3C_BYTE_W 8

`define I3C_BROADCAST_ADDR 7'h7E

`define I3C_CFG_DATA_W 16

`endif

/* hw/i3c_ctrl_top.sv */
//////////////////////////////////////////////////
// I3C/I2C target front end. Bus monitor, config
// registers and address receiver wired together.
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i3c_consts.svh"

module i3c_ctrl_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        scl_i,
  input  logic                        sda_i,
  input  logic                        cfg_wr_i,
  input  i3c_cfg_pkg::cfg_reg_e       cfg_sel_i,
  input  logic [`I3C_CFG_DATA_W-1:0]  cfg_wdata_i,
  output logic                        bus_start_o,
  output logic                        bus_rstart_o,
  output logic                        bus_stop_o,
  output logic [`I3C_BYTE_W-1:0]      bus_addr_o,
  output logic                        bus_addr_valid_o,
  output logic                        addr_match_o,
  output logic                        xfer_in_progress_o
);

  import i3c_bus_pkg::*;
  import i3c_cfg_pkg::*;

  cfg_t       cfg;
  bus_state_t bus_state;

  ctrl_config u_config (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cfg_wr_i    (cfg_wr_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  bus_monitor u_bus_monitor (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .filt_cycles_i (cfg.filt_cycles),
    .enable_i      (cfg.enable),
    .state_o       (bus_state)
  );

  addr_receiver u_addr_receiver (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .bus_i              (bus_state),
    .cfg_i              (cfg),
    .bus_addr_o         (bus_addr_o),
    .bus_addr_valid_o   (bus_addr_valid_o),
    .addr_match_o       (addr_match_o),
    .xfer_in_progress_o (xfer_in_progress_o)
  );

  // Bus conditions straight from the monitor
  assign bus_start_o  = bus_state.start;
  assign bus_rstart_o = bus_state.rstart;
  assign bus_stop_o   = bus_state.stop;

endmodule

/* list.f */
+incdir+hw
hw/i3c_bus_pkg.sv
hw/i3c_cfg_pkg.sv
hw/bus_monitor.sv
hw/ctrl_config.sv
hw/addr_receiver.sv
hw/i3c_ctrl_top.sv
verification/tb_i3c_ctrl.sv

/* verification/addr_cases.txt */
# name W sel data (hex); sel 0 static, 1 dynamic (bit 7 valid), 2 filter, 3 enable
# name T byte1 rs byte2 glitch_w glitch_seen match1 match2 (bytes hex, rest decimal)
dis_first     T a4 0 00 0 0 0 0
en_on         W 3 0001
sta_set       W 0 00d2
sta_write     T a4 0 00 0 0 1 0
sta_read      T a5 0 00 0 0 1 0
dyn_set       W 1 00b1
dyn_match     T 62 0 00 0 0 1 0
bcast         T fc 0 00 0 0 1 0
no_match      T 20 0 00 0 0 0 0
sta_clear     W 0 0052
sta_invalid   T a4 0 00 0 0 0 0
sta_again     W 0 00d2
rstart_pair   T fc 1 a5 0 0 1 1
rstart_mixed  T 20 1 63 0 0 0 1
# Glitch rejection, then acceptance once the filter is narrowed
filt_wide     W 2 0008
glitch_short  T a4 0 00 4 0 1 0
filt_narrow   W 2 0002
glitch_long   T 62 0 00 6 1 1 0
filt_restore  W 2 0004
en_off        W 3 0000
dis_again     T a4 1 62 0 0 0 0
en_back       W 3 0001
last_xfer     T 2a 0 00 0 0 0 0

/* verification/tb_i3c_ctrl.sv */
//////////////////////////////////////////////////
// Self-checking testbench for the I3C target front
// end. Bit-bangs SCL/SDA from the case file and
// checks condition strobes, address bytes and matches.
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "i3c_consts.svh"

module tb_i3c_ctrl;

  import i3c_cfg_pkg::*;

  localparam int HALF = 12;
  localparam int QUARTER = HALF / 2;
  localparam int MAX_CASES = 64;
  localparam int CASE_CYCLES = 60 * HALF;
  localparam int SEED = 89736;

  logic                       clk_i;
  logic                       rst_i;
  logic                       scl_i;
  logic                       sda_i;
  logic                       cfg_wr_i;
  cfg_reg_e                   cfg_sel_i;
  logic [`I3C_CFG_DATA_W-1:0] cfg_wdata_i;
  logic                       bus_start_o;
  logic                       bus_rstart_o;
  logic                       bus_stop_o;
  logic [`I3C_BYTE_W-1:0]     bus_addr_o;
  logic                       bus_addr_valid_o;
  logic                       addr_match_o;
  logic                       xfer_in_progress_o;

  // Case table, args per op as described in the case file
  string c_name [MAX_CASES];
  string c_op [MAX_CASES];
  int    c_arg [MAX_CASES][7];
  int    n_cases = 0;
  bit    loaded = 1'b0;

  bit en_model = 1'b0;
  int filt_model = `I3C_FILT_RESET;
  int n_checks = 0;
  int mismatches = 0;
  int other_errors = 0;

  int start_cnt = 0;
  int rstart_cnt = 0;
  int stop_cnt = 0;
  int xfer_cycles = 0;
  logic [`I3C_BYTE_W-1:0] addr_seen [$];
  logic                   match_seen [$];

  i3c_ctrl_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Strobes sampled mid-cycle
  always @(negedge clk_i) begin
    if (bus_start_o) start_cnt++;
    if (bus_rstart_o) rstart_cnt++;
    if (bus_stop_o) stop_cnt++;
    if (xfer_in_progress_o) xfer_cycles++;
    if (bus_addr_valid_o) begin
      addr_seen.push_back(bus_addr_o);
      match_seen.push_back(addr_match_o);
    end
  end

  task automatic check_val(input string name, input int exp_val, input int act_val);
    n_checks++;
    if (exp_val != act_val) begin
      mismatches++;
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
    end
  endtask

  task automatic set_lines(input logic scl, input logic sda, input int cycles);
    @(posedge clk_i);
    scl_i <= scl;
    sda_i <= sda;
    repeat (cycles - 1) @(posedge clk_i);
  endtask

  // SDA changes mid way through SCL low
  task automatic send_byte(input logic [`I3C_BYTE_W-1:0] b);
    logic [`I3C_BYTE_W:0] bits;
    bits = {b, 1'b1};
    for (int i = `I3C_BYTE_W; i >= 0; i--) begin
      set_lines(1'b0, sda_i, QUARTER);
      set_lines(1'b0, bits[i], HALF - QUARTER);
      set_lines(1'b1, bits[i], HALF);
    end
  endtask

  task automatic write_cfg(input int sel, input int data);
    @(posedge clk_i);
    cfg_wr_i    <= 1'b1;
    cfg_sel_i   <= cfg_reg_e'(sel[1:0]);
    cfg_wdata_i <= `I3C_CFG_DATA_W'(data);
    @(posedge clk_i);
    cfg_wr_i <= 1'b0;
    if (cfg_reg_e'(sel[1:0]) == REG_FILT) filt_model = int'(data[7:0]);
    if (cfg_reg_e'(sel[1:0]) == REG_ENABLE) en_model = data[0];
  endtask

  task automatic run_transfer(input int idx);
    string nm;
    int    rs;
    int    gw;
    int    nconds;
    int    nbytes;
    int    base_s;
    int    base_r;
    int    base_p;
    int    base_x;
    int    base_a;
    int    n;
    bit    seen;
    nm = c_name[idx];
    rs = c_arg[idx][1];
    gw = c_arg[idx][3];
    base_s = start_cnt;
    base_r = rstart_cnt;
    base_p = stop_cnt;
    base_x = xfer_cycles;
    base_a = addr_seen.size();
    if (gw > 0) begin
      // Short SDA low pulse while SCL is high
      set_lines(1'b1, 1'b0, gw);
      set_lines(1'b1, 1'b1, 2 * HALF);
    end
    set_lines(1'b1, 1'b0, HALF);
    send_byte(`I3C_BYTE_W'(c_arg[idx][0]));
    if (rs != 0) begin
      set_lines(1'b0, 1'b1, HALF);
      set_lines(1'b1, 1'b1, HALF);
      set_lines(1'b1, 1'b0, HALF);
      send_byte(`I3C_BYTE_W'(c_arg[idx][2]));
    end
    set_lines(1'b0, 1'b1, QUARTER);
    set_lines(1'b0, 1'b0, HALF - QUARTER);
    set_lines(1'b1, 1'b0, HALF);
    set_lines(1'b1, 1'b1, 1);
    // Bounded by sync plus filter plus decode latency
    seen = 1'b0;
    n = 0;
    while (!seen && n < `I3C_SYNC_STAGES + filt_model + 4) begin
      @(negedge clk_i);
      seen = bus_stop_o;
      n++;
    end
    if (en_model && !seen) begin
      other_errors++;
      $display("Case %s: no STOP strobe after the STOP on the bus", nm);
    end
    @(negedge clk_i);
    check_val({nm, ".xfer_end"}, 0, int'(xfer_in_progress_o));
    nconds = en_model ? 1 + c_arg[idx][4] : 0;
    nbytes = en_model ? 1 + rs : 0;
    check_val({nm, ".start"}, nconds, start_cnt - base_s);
    check_val({nm, ".stop"}, nconds, stop_cnt - base_p);
    check_val({nm, ".rstart"}, en_model ? rs : 0, rstart_cnt - base_r);
    check_val({nm, ".xfer_seen"}, int'(en_model), int'(xfer_cycles != base_x));
    check_val({nm, ".bytes"}, nbytes, addr_seen.size() - base_a);
    for (int k = 0; k < nbytes && base_a + k < addr_seen.size(); k++) begin
      check_val({nm, ".addr"}, c_arg[idx][2 * k] & 'hff, int'(addr_seen[base_a + k]));
      check_val({nm, ".match"}, c_arg[idx][5 + k], int'(match_seen[base_a + k]));
    end
  endtask

  initial begin
    int    fd;
    int    code;
    int    gap;
    string tok;
    string line;
    void'($urandom(SEED));
    scl_i       <= 1'b1;
    sda_i       <= 1'b1;
    cfg_wr_i    <= 1'b0;
    cfg_sel_i   <= REG_STA_ADDR;
    cfg_wdata_i <= '0;
    rst_i       <= 1'b1;
    fd = $fopen("verification/addr_cases.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the case file");
    end else begin
      while (n_cases < MAX_CASES && $fscanf(fd, "%s", tok) == 1) begin
        if (tok[0] == "#") begin
          void'($fgets(line, fd));
        end else begin
          c_name[n_cases] = tok;
          code = $fscanf(fd, "%s", c_op[n_cases]);
          if (c_op[n_cases] == "W") begin
            code += $fscanf(fd, "%h %h", c_arg[n_cases][0], c_arg[n_cases][1]);
            if (code != 3) begin
              other_errors++;
              $display("Case %s: the configuration write line is incomplete", tok);
            end
          end else begin
            code += $fscanf(fd, "%h %d %h %d %d %d %d", c_arg[n_cases][0],
                            c_arg[n_cases][1], c_arg[n_cases][2], c_arg[n_cases][3],
                            c_arg[n_cases][4], c_arg[n_cases][5], c_arg[n_cases][6]);
            if (code != 8) begin
              other_errors++;
              $display("Case %s: the transfer line is incomplete", tok);
            end
          end
          n_cases++;
        end
      end
      $fclose(fd);
    end
    if (n_cases == 0) begin
      other_errors++;
      $display("No cases were read from the case file");
    end
    loaded = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < n_cases; i++) begin
      if (c_op[i] == "W") begin
        write_cfg(c_arg[i][0], c_arg[i][1]);
      end else if (c_op[i] == "T") begin
        run_transfer(i);
      end else begin
        other_errors++;
        $display("Case %s: unknown operation %s", c_name[i], c_op[i]);
      end
      gap = int'($urandom % 4);
      repeat (gap + 1) @(posedge clk_i);
    end
    $display("Checks %0d, mismatches %0d, other errors %0d",
             n_checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog sized from the case count
  initial begin
    wait (loaded);
    repeat ((n_cases * CASE_CYCLES + 16) * 2) @(posedge clk_i);
    $display("Timeout: the cases did not finish in the expected time");
    $display("TB FAILED");
    $finish;
  end

endmodule
